//--- common/vfb_defines.svh
/* frame buffer read constants */

`ifndef VFB_DEFINES_SVH
`define VFB_DEFINES_SVH

// display raster
`define VFB_H_WIDTH              1280
`define VFB_V_HEIGHT             720
`define VFB_PIXEL_BITS           16

// controller side
`define VFB_DATA_WIDTH           256
`define VFB_ADDR_WIDTH           28
`define VFB_UNIT_BITS            32    // one address unit
`define VFB_BURST_LEN            10
`define VFB_ARSIZE               5     // 32 bytes per beat

// memory map, in address units
`define VFB_FRAME_OFFSET         30000 // bank 1 above bank 0
`define VFB_TILE_SPACING         60000

// quarter-size tiles
`define VFB_TILE_WIDTH           (`VFB_H_WIDTH / 4)
`define VFB_TILE_HEIGHT          (`VFB_V_HEIGHT / 4)
`define VFB_BEATS_PER_TILE_LINE  (`VFB_TILE_WIDTH * `VFB_PIXEL_BITS / `VFB_DATA_WIDTH)
`define VFB_BURSTS_PER_TILE_LINE (`VFB_BEATS_PER_TILE_LINE / `VFB_BURST_LEN)
`define VFB_BEATS_PER_LINE       (`VFB_BEATS_PER_TILE_LINE * 4)
`define VFB_ADDR_STEP            (`VFB_BURST_LEN * `VFB_DATA_WIDTH / `VFB_UNIT_BITS)
`define VFB_TILE_FRAME_UNITS     \
    (`VFB_TILE_WIDTH * `VFB_TILE_HEIGHT * `VFB_PIXEL_BITS / `VFB_UNIT_BITS)

`endif

//--- common/vfb_pkg.sv
/* frame buffer read types */

package vfb_pkg;

    `include "vfb_defines.svh"

    // ddr controller address
    typedef logic [`VFB_ADDR_WIDTH-1:0] axi_addr_t;

    // one read data beat
    typedef logic [`VFB_DATA_WIDTH-1:0] beat_t;

    // tile 0..3, left to right on the output line
    typedef logic [1:0] tile_idx_t;

    // burst within one tile line
    typedef logic [0:0] burst_idx_t;

    // beat position in the line buffer, 0..79
    typedef logic [6:0] col_addr_t;

    typedef enum logic [1:0] {
        idle,
        ar_wait,   // arvalid up, waiting for arready
        data_wait  // burst in flight
    } seq_state_t;

endpackage

//--- hdl/line_buffer_writer.sv
/* line buffer write port */

`timescale 1ns/1ps

`include "vfb_defines.svh"

module line_buffer_writer
    import vfb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      axi_rvalid,
    input  beat_t     axi_rdata,
    output logic      buf_wr_en,
    output beat_t     buf_wr_data,
    output col_addr_t buf_wr_addr
);

    localparam col_addr_t LAST_COL = col_addr_t'(`VFB_BEATS_PER_LINE - 1);

    col_addr_t col;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_wr_en   <= 1'b0;
            buf_wr_addr <= '0;
            col         <= '0;
        end else begin
            buf_wr_en <= axi_rvalid;
            if (axi_rvalid) begin
                buf_wr_addr <= col;
                col         <= (col == LAST_COL) ? '0 : col + col_addr_t'(1); // next line
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axi_rvalid) begin
            buf_wr_data <= axi_rdata;
        end
    end

endmodule

//--- hdl/line_trigger.sv
/* display timing edge detect */

`timescale 1ns/1ps

module line_trigger (
    input  logic clk,
    input  logic rst,
    input  logic hdmi_vsync,
    input  logic hdmi_href,
    input  logic init_done,
    output logic frame_start,
    output logic line_req
);

    logic vsync_d;
    logic href_d;
    logic vsync_rise;
    logic vsync_fall;
    logic href_fall;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vsync_d <= 1'b0;
            href_d  <= 1'b0;
        end else begin
            vsync_d <= hdmi_vsync;
            href_d  <= hdmi_href;
        end
    end

    assign vsync_rise = hdmi_vsync & ~vsync_d;
    assign vsync_fall = ~hdmi_vsync & vsync_d;
    assign href_fall  = ~hdmi_href & href_d;

    // nothing goes out until ddr calibration is done
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            frame_start <= 1'b0;
            line_req    <= 1'b0;
        end else begin
            frame_start <= init_done & vsync_rise;
            // end of vsync fetches the first line
            line_req    <= init_done & (vsync_fall | href_fall);
        end
    end

endmodule

//--- hdl/quad_view_reader.sv
/* quad view frame buffer reader */

`timescale 1ns/1ps

`include "vfb_defines.svh"

module quad_view_reader
    import vfb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       hdmi_vsync,
    input  logic       hdmi_href,
    input  logic       init_done,

    output logic       axi_arvalid,
    input  logic       axi_arready,
    output axi_addr_t  axi_araddr,
    output logic [3:0] axi_arid,
    output logic [3:0] axi_arlen,
    output logic [2:0] axi_arsize,
    output logic [1:0] axi_arburst,

    output logic       axi_rready,
    input  beat_t      axi_rdata,
    input  logic       axi_rvalid,
    input  logic       axi_rlast,
    input  logic [3:0] axi_rid,

    output logic       buf_wr_en,
    output beat_t      buf_wr_data,
    output col_addr_t  buf_wr_addr
);

    logic      frame_start;
    logic      line_req;
    tile_idx_t tile_sel;
    logic      addr_advance;
    logic      beat_accept;

    assign axi_arid    = 4'd0;
    assign axi_arlen   = 4'(`VFB_BURST_LEN - 1);
    assign axi_arsize  = 3'(`VFB_ARSIZE);
    assign axi_arburst = 2'b01; // incr

    // never back-pressures data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            axi_rready <= 1'b0;
        end else begin
            axi_rready <= 1'b1;
        end
    end

    // only beats carrying our id
    assign beat_accept = axi_rvalid & axi_rready & (axi_rid == axi_arid);

    line_trigger line_trigger_i (
        .clk         (clk),
        .rst         (rst),
        .hdmi_vsync  (hdmi_vsync),
        .hdmi_href   (hdmi_href),
        .init_done   (init_done),
        .frame_start (frame_start),
        .line_req    (line_req)
    );

    tile_sequencer tile_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .line_req     (line_req),
        .axi_arready  (axi_arready),
        .axi_rvalid   (beat_accept),
        .axi_rlast    (axi_rlast),
        .axi_arvalid  (axi_arvalid),
        .tile_sel     (tile_sel),
        .addr_advance (addr_advance)
    );

    tile_addr_gen tile_addr_gen_i (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .tile_sel     (tile_sel),
        .addr_advance (addr_advance),
        .axi_araddr   (axi_araddr)
    );

    line_buffer_writer line_buffer_writer_i (
        .clk         (clk),
        .rst         (rst),
        .axi_rvalid  (beat_accept),
        .axi_rdata   (axi_rdata),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_data (buf_wr_data),
        .buf_wr_addr (buf_wr_addr)
    );

endmodule

//--- rd_sequencer/tile_addr_gen.sv
/* tile read address generator */

`timescale 1ns/1ps

`include "vfb_defines.svh"

module tile_addr_gen
    import vfb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      frame_start,
    input  tile_idx_t tile_sel,
    input  logic      addr_advance,
    output axi_addr_t axi_araddr
);

    localparam axi_addr_t STEP        = axi_addr_t'(`VFB_ADDR_STEP);
    localparam axi_addr_t FRAME_UNITS = axi_addr_t'(`VFB_TILE_FRAME_UNITS);
    localparam axi_addr_t BANK_OFFSET = axi_addr_t'(`VFB_FRAME_OFFSET);
    localparam axi_addr_t SPACING     = axi_addr_t'(`VFB_TILE_SPACING);

    axi_addr_t offset [4];  // read position inside the current bank
    logic [3:0] bank;       // bank being read, per tile
    axi_addr_t step_offset;
    logic      frame_wrap;
    axi_addr_t tile_base;
    axi_addr_t bank_base;

    assign step_offset = offset[tile_sel] + STEP;
    assign frame_wrap  = (step_offset >= FRAME_UNITS);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            offset <= '{default: '0};
            bank   <= '0;
        end else if (frame_start) begin
            offset <= '{default: '0}; // banks kept
        end else if (addr_advance) begin
            if (frame_wrap) begin
                offset[tile_sel] <= '0;
                bank[tile_sel]   <= ~bank[tile_sel];
            end else begin
                offset[tile_sel] <= step_offset;
            end
        end
    end

    assign tile_base = axi_addr_t'(tile_sel) * SPACING;
    assign bank_base = bank[tile_sel] ? BANK_OFFSET : '0;

    // stable while arvalid waits, offsets only move on the transfer
    assign axi_araddr = tile_base + bank_base + offset[tile_sel];

endmodule

//--- rd_sequencer/tile_sequencer.sv
/* four-tile burst sequencer */

`timescale 1ns/1ps

`include "vfb_defines.svh"

module tile_sequencer
    import vfb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_req,
    input  logic       axi_arready,
    input  logic       axi_rvalid,
    input  logic       axi_rlast,
    output logic       axi_arvalid,
    output tile_idx_t  tile_sel,
    output logic       addr_advance
);

    localparam tile_idx_t  LAST_TILE  = tile_idx_t'(3);
    localparam burst_idx_t LAST_BURST = burst_idx_t'(`VFB_BURSTS_PER_TILE_LINE - 1);

    seq_state_t state;
    seq_state_t state_nxt;
    tile_idx_t  tile_cnt;
    burst_idx_t burst_cnt;
    logic       ar_done;
    logic       burst_done;
    logic       line_done;

    assign axi_arvalid  = (state == ar_wait);
    assign ar_done      = axi_arvalid & axi_arready;
    assign burst_done   = (state == data_wait) & axi_rvalid & axi_rlast;
    assign line_done    = (tile_cnt == LAST_TILE) && (burst_cnt == LAST_BURST);

    assign addr_advance = ar_done;
    assign tile_sel     = tile_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (line_req) begin
                    state_nxt = ar_wait;
                end
            end
            ar_wait: begin
                if (ar_done) begin
                    state_nxt = data_wait;
                end
            end
            data_wait: begin
                if (burst_done) begin
                    state_nxt = line_done ? idle : ar_wait;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // tile and burst position within the line
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tile_cnt  <= '0;
            burst_cnt <= '0;
        end else if (state == idle) begin
            tile_cnt  <= '0;
            burst_cnt <= '0;
        end else if (burst_done) begin
            if (burst_cnt == LAST_BURST) begin
                burst_cnt <= '0;
                tile_cnt  <= tile_cnt + tile_idx_t'(1); // wraps to 0 after tile 3
            end else begin
                burst_cnt <= burst_cnt + burst_idx_t'(1);
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the quad view reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f src.f --top-module quad_view_reader_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
    exit 0
fi
echo "simulation reported failure"
exit 1

//--- src.f
+incdir+common
common/vfb_pkg.sv
hdl/line_trigger.sv
rd_sequencer/tile_sequencer.sv
rd_sequencer/tile_addr_gen.sv
hdl/line_buffer_writer.sv
hdl/quad_view_reader.sv
tests/tb_clock.sv
tests/quad_view_reader_tb.sv

//--- tests/quad_view_reader_tb.sv
/* quad view reader testbench */

`timescale 1ns/1ps

`include "vfb_defines.svh"

module quad_view_reader_tb
    import vfb_pkg::*;
;

    localparam int STEP       = `VFB_ADDR_STEP;
    localparam int FRAME      = `VFB_TILE_FRAME_UNITS;
    localparam int SPACING    = `VFB_TILE_SPACING;
    localparam int BANK_OFS   = `VFB_FRAME_OFFSET;
    localparam int WAIT_LIMIT = 200;

    logic       clk;
    logic       rst;
    logic       hdmi_vsync;
    logic       hdmi_href;
    logic       init_done;
    logic       axi_arvalid;
    logic       axi_arready;
    axi_addr_t  axi_araddr;
    logic [3:0] axi_arid;
    logic [3:0] axi_arlen;
    logic [2:0] axi_arsize;
    logic [1:0] axi_arburst;
    logic       axi_rready;
    beat_t      axi_rdata;
    logic       axi_rvalid;
    logic       axi_rlast;
    logic [3:0] axi_rid;
    logic       buf_wr_en;
    beat_t      buf_wr_data;
    col_addr_t  buf_wr_addr;

    logic [31:0] rng = 32'h6846e3de;
    int          errors = 0;
    int          timeouts = 0;
    int          ar_count = 0;
    int          lines = 0;
    int          model_off [4] = '{default: 0};
    int          model_bank [4] = '{default: 0};
    axi_addr_t   got_first [4];
    col_addr_t   exp_col = '0;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    quad_view_reader quad_view_reader_i (.*);

    // address transfers seen on the bus
    always @(posedge clk) begin
        if (axi_arvalid && axi_arready) begin
            ar_count <= ar_count + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_below(input int n, output int v);
        rng = xorshift32(rng);
        v = int'(rng % 32'(n));
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_col(input string name, input col_addr_t got, input col_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_field(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_and_finish;
        $display("error count: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    function automatic axi_addr_t model_addr(input int t);
        int a;
        a = t * SPACING + model_bank[t] * BANK_OFS + model_off[t];
        return axi_addr_t'(a);
    endfunction

    task automatic model_advance(input int t);
        if (model_off[t] + STEP >= FRAME) begin
            model_off[t]  = 0;
            model_bank[t] = 1 - model_bank[t];
        end else begin
            model_off[t] = model_off[t] + STEP;
        end
    endtask

    // one clock, then check the line buffer port against the beat just accepted
    task automatic step;
        logic  took;
        beat_t data;
        took = axi_rvalid; // rready is always high
        data = axi_rdata;
        @(posedge clk);
        #2;
        check_flag("buf_wr_en", buf_wr_en, took);
        if (took) begin
            check_beat("buf_wr_data", buf_wr_data, data);
            check_col("buf_wr_addr", buf_wr_addr, exp_col);
            exp_col = (exp_col == col_addr_t'(`VFB_BEATS_PER_LINE - 1)) ? '0
                                                                        : exp_col + col_addr_t'(1);
        end
    endtask

    task automatic serve_burst(input int t, input int b);
        int        n;
        int        delay;
        int        gap;
        axi_addr_t hold;
        beat_t     data;
        if (timeouts != 0) begin
            return;
        end
        n = 0;
        while (!axi_arvalid && n < WAIT_LIMIT) begin
            step;
            n++;
        end
        if (!axi_arvalid) begin
            $display("ERROR: timeout waiting for arvalid, tile %0d burst %0d", t, b);
            timeouts++;
            return;
        end
        hold = axi_araddr;
        if (b == 0) begin
            got_first[t] = hold;
        end
        check_addr("axi_araddr", hold, model_addr(t));
        check_field("axi_arid", axi_arid, 4'd0);
        check_field("axi_arlen", axi_arlen, 4'd9);
        check_field("axi_arsize", {1'b0, axi_arsize}, 4'd5);
        check_field("axi_arburst", {2'b00, axi_arburst}, 4'd1);
        check_flag("axi_rready", axi_rready, 1'b1);
        rand_below(4, delay);
        repeat (delay) begin
            step;
            check_flag("axi_arvalid held", axi_arvalid, 1'b1);
            check_addr("axi_araddr held", axi_araddr, hold);
        end
        axi_arready = 1'b1;
        step;
        axi_arready = 1'b0;
        model_advance(t);
        check_flag("axi_arvalid after transfer", axi_arvalid, 1'b0);
        // ten beats, tagged with burst address and beat number
        for (int i = 0; i < `VFB_BURST_LEN; i++) begin
            rand_below(4, gap);
            if (gap == 0) begin
                rand_below(3, gap);
                gap++;
            end else begin
                gap = 0;
            end
            repeat (gap) begin
                axi_rvalid = 1'b0;
                axi_rlast  = 1'b0;
                step;
            end
            data = '0;
            data[`VFB_DATA_WIDTH-1 -: `VFB_ADDR_WIDTH] = hold;
            data[7:0] = 8'(i);
            axi_rdata  = data;
            axi_rvalid = 1'b1;
            axi_rlast  = (i == `VFB_BURST_LEN - 1);
            step;
        end
        axi_rvalid = 1'b0;
        axi_rlast  = 1'b0;
    endtask

    task automatic run_line(input logic by_vsync);
        int gap;
        if (timeouts != 0) begin
            return;
        end
        if (by_vsync) begin
            hdmi_vsync = 1'b1;
            model_off  = '{default: 0}; // banks stay
            step;
            step;
            hdmi_vsync = 1'b0;
        end else begin
            hdmi_href = 1'b1;
            step;
            step;
            hdmi_href = 1'b0;
        end
        for (int t = 0; t < 4; t++) begin
            for (int b = 0; b < `VFB_BURSTS_PER_TILE_LINE; b++) begin
                serve_burst(t, b);
            end
        end
        if (timeouts != 0) begin
            return;
        end
        step;
        step;
        check_flag("axi_arvalid after line", axi_arvalid, 1'b0);
        lines++;
        check_count("address transfers", ar_count, lines * 8);
        rand_below(16, gap);
        repeat (gap) step;
    endtask

    // first burst of each tile should sit at offset 0 of the given bank
    task automatic check_line_start(input int bank);
        if (timeouts != 0) begin
            return;
        end
        for (int t = 0; t < 4; t++) begin
            check_addr("first araddr of line", got_first[t],
                       axi_addr_t'(t * SPACING + bank * BANK_OFS));
        end
    endtask

    initial begin
        int n;
        int r;
        hdmi_vsync  = 1'b0;
        hdmi_href   = 1'b0;
        init_done   = 1'b0;
        axi_arready = 1'b0;
        axi_rdata   = '0;
        axi_rvalid  = 1'b0;
        axi_rlast   = 1'b0;
        axi_rid     = 4'd0;
        n = 0;
        while (!rst && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rst) begin
            $display("ERROR: reset never released");
            timeouts++;
        end else begin
            #2;

            // timing edges while ddr is still calibrating
            for (int i = 0; i < 24; i++) begin
                rand_below(4, r);
                hdmi_vsync = r[0];
                hdmi_href  = r[1];
                step;
                check_flag("axi_arvalid before init_done", axi_arvalid, 1'b0);
            end
            hdmi_vsync = 1'b0;
            hdmi_href  = 1'b0;
            repeat (3) step;
            check_count("address transfers before init_done", ar_count, 0);
            init_done = 1'b1;
            repeat (4) step;

            repeat (`VFB_TILE_HEIGHT) run_line(1'b0);
            run_line(1'b0);
            check_line_start(1);  // first wrap

            repeat (59) run_line(1'b0);
            run_line(1'b1);
            check_line_start(1);  // mid-frame vsync

            repeat (`VFB_TILE_HEIGHT - 1) run_line(1'b0);
            run_line(1'b0);
            check_line_start(0);  // second wrap
        end

        report_and_finish;
    end

endmodule

//--- tests/tb_clock.sv
/* testbench clock and reset */

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b1;
    end

endmodule
